// File: run.sh
#!/bin/sh
# Build and run the ALU pipeline testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module aluPipeTb -Mdir build
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./build/ValuPipeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: source/aluExecute.sv
// Execute stage: single-cycle ALU plus the retire register.
`timescale 1ns/1ps
`default_nettype none

module aluExecute import rvAluPkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire decodedT decoded,
    output retireT       retired
);

    xlenT       result;
    xlenT       opA;
    xlenT       opB;
    logic [4:0] shamt;

    assign opA   = decoded.operandA;
    assign opB   = decoded.operandB;
    assign shamt = opB[4:0];   // shift amount mod 32

    always_comb begin
        case (decoded.opSel)
            ADD:     result = opA + opB;
            SUB:     result = opA - opB;
            SLT:     result = {31'd0, $signed(opA) < $signed(opB)};
            SLTU:    result = {31'd0, opA < opB};
            SLL:     result = opA << shamt;
            SRL:     result = opA >> shamt;
            SRA:     result = xlenT'($signed(opA) >>> shamt);   // sign fill
            AND:     result = opA & opB;
            OR:      result = opA | opB;
            XOR:     result = opA ^ opB;
            LUI:     result = opB;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retired.valid       <= 1'b0;
            retired.writeEnable <= 1'b0;
        end else begin
            retired.valid       <= decoded.valid;
            retired.writeEnable <= decoded.writeEnable;
        end
        retired.rd     <= decoded.rd;
        retired.result <= result;
    end

endmodule : aluExecute

`default_nettype wire

// File: source/aluOpDecode.sv
// Combinational ALU control. Undefined funct3/funct7 combinations fall back to ADD.
`timescale 1ns/1ps
`default_nettype none

module aluOpDecode import rvAluPkg::*; (
    input  wire instClassT aluOp,
    input  wire funct7T    funct7,
    input  wire funct3T    funct3,
    output aluOpT          opSel
);

    always_comb begin
        opSel = ADD;
        case (aluOp)
            immType: begin
                case (funct3)
                    funct3AddSub: opSel = ADD;
                    funct3Sll:    opSel = SLL;
                    funct3Slt:    opSel = SLT;
                    funct3Sltu:   opSel = SLTU;
                    funct3Xor:    opSel = XOR;
                    funct3SrlSra: opSel = funct7[5] ? SRA : SRL;   // instr bit 30
                    funct3Or:     opSel = OR;
                    funct3And:    opSel = AND;
                    default:      opSel = ADD;
                endcase
            end
            regType: begin
                if (funct7 == funct7Base) begin
                    case (funct3)
                        funct3AddSub: opSel = ADD;
                        funct3Sll:    opSel = SLL;
                        funct3Slt:    opSel = SLT;
                        funct3Sltu:   opSel = SLTU;
                        funct3Xor:    opSel = XOR;
                        funct3SrlSra: opSel = SRL;
                        funct3Or:     opSel = OR;
                        funct3And:    opSel = AND;
                        default:      opSel = ADD;
                    endcase
                end else if (funct7 == funct7Alt) begin
                    if (funct3 == funct3AddSub) begin
                        opSel = SUB;
                    end else if (funct3 == funct3SrlSra) begin
                        opSel = SRA;
                    end
                end
            end
            upperType: opSel = LUI;
            default:   opSel = ADD;
        endcase
    end

endmodule : aluOpDecode

`default_nettype wire

// File: source/aluPipeTop.sv
// Two-stage RV32I ALU pipeline, two cycles from instValid to retired.
`timescale 1ns/1ps
`default_nettype none

module aluPipeTop import rvAluPkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          instValid,
    input  wire xlenT    instWord,
    input  wire regAddrT debugAddr,
    output xlenT         debugData,
    output retireT       retired
);

    decodedT decoded;
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    xlenT    rs1Data;
    xlenT    rs2Data;

    instrDecode iDecode (
        .clk       (clk),
        .reset     (reset),
        .instValid (instValid),
        .instWord  (instWord),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .retired   (retired),
        .decoded   (decoded)
    );

    aluExecute iExecute (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .retired (retired)
    );

    regFile iRegFile (
        .clk       (clk),
        .reset     (reset),
        .retired   (retired),   // write port
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .debugAddr (debugAddr),
        .debugData (debugData)
    );

endmodule : aluPipeTop

`default_nettype wire

// File: source/instrDecode.sv
// Decode stage: one instruction per cycle, no back-pressure.
// A distance-1 dependency is patched on the decoded operands from the retire register.
`timescale 1ns/1ps
`default_nettype none

module instrDecode import rvAluPkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          instValid,
    input  wire xlenT    instWord,
    output regAddrT      rs1Addr,
    output regAddrT      rs2Addr,
    input  wire xlenT    rs1Data,
    input  wire xlenT    rs2Data,
    input  wire retireT  retired,
    output decodedT      decoded
);

    opcodeT    opcode;
    instClassT instClass;
    aluOpT     opSel;
    xlenT      imm;
    decodedT   pipeReg;
    logic      fwdA;     // operand comes from the instruction ahead
    logic      fwdB;

    function automatic logic writesReg(logic valid, logic writeEnable, regAddrT rd,
                                       regAddrT addr);
        return valid && writeEnable && (rd != '0) && (rd == addr);
    endfunction

    assign opcode  = instWord[6:0];
    assign rs1Addr = instWord[19:15];
    assign rs2Addr = instWord[24:20];

    always_comb begin
        case (opcode)
            opcodeOp:    instClass = regType;
            opcodeOpImm: instClass = immType;
            opcodeLui:   instClass = upperType;
            default:     instClass = noOp;
        endcase
    end

    always_comb begin
        case (instClass)
            immType:   imm = {{20{instWord[31]}}, instWord[31:20]};
            upperType: imm = {instWord[31:12], 12'h000};
            default:   imm = '0;
        endcase
    end

    aluOpDecode iAluOpDecode (
        .aluOp  (instClass),
        .funct7 (instWord[31:25]),
        .funct3 (instWord[14:12]),
        .opSel  (opSel)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pipeReg.valid       <= 1'b0;
            pipeReg.writeEnable <= 1'b0;
            fwdA                <= 1'b0;
            fwdB                <= 1'b0;
        end else begin
            pipeReg.valid       <= instValid;
            pipeReg.writeEnable <= instValid && (instClass != noOp);
            // previous instruction still in execute, its result lands in retired next
            fwdA <= instValid &&
                    writesReg(pipeReg.valid, pipeReg.writeEnable, pipeReg.rd, rs1Addr);
            fwdB <= instValid && (instClass == regType) &&
                    writesReg(pipeReg.valid, pipeReg.writeEnable, pipeReg.rd, rs2Addr);
        end
        pipeReg.rd       <= instWord[11:7];
        pipeReg.opSel    <= opSel;
        pipeReg.operandA <= rs1Data;   // regfile passes the retiring write through
        pipeReg.operandB <= (instClass == regType) ? rs2Data : imm;
    end

    always_comb begin
        decoded = pipeReg;
        if (fwdA) begin
            decoded.operandA = retired.result;
        end
        if (fwdB) begin
            decoded.operandB = retired.result;
        end
    end

endmodule : instrDecode

`default_nettype wire

// File: source/regFile.sv
// 32x32 register file, x0 reads zero. Reads pass a same-cycle write through
// except on the debug port, which shows the stored value.
`timescale 1ns/1ps
`default_nettype none

module regFile import rvAluPkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire retireT  retired,
    input  wire regAddrT rs1Addr,
    input  wire regAddrT rs2Addr,
    output xlenT         rs1Data,
    output xlenT         rs2Data,
    input  wire regAddrT debugAddr,
    output xlenT         debugData
);

    xlenT regs [1:31];
    logic wrEn;

    assign wrEn = retired.valid && retired.writeEnable && (retired.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[retired.rd] <= retired.result;
        end
    end

    function automatic xlenT readPort(regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        return (wrEn && retired.rd == addr) ? retired.result : regs[addr];
    endfunction

    always_comb begin
        rs1Data   = readPort(rs1Addr);
        rs2Data   = readPort(rs2Addr);
        debugData = (debugAddr == '0) ? '0 : regs[debugAddr];
    end

endmodule : regFile

`default_nettype wire

// File: source/rvAluPkg.sv
// Shared types for the RV32I execute pipeline. XLEN is fixed at 32 with 32 registers.
// Only the OP, OP-IMM and LUI opcodes are known here.
`default_nettype none

package rvAluPkg;

    typedef logic [31:0] xlenT;
    typedef logic [4:0]  regAddrT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;
    typedef logic [6:0]  opcodeT;

    // ALU control class fed to aluOpDecode
    typedef enum logic [1:0] {
        noOp      = 2'b00,
        upperType = 2'b01,
        regType   = 2'b10,
        immType   = 2'b11
    } instClassT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        AND,
        OR,
        XOR,
        LUI     // passes operand B
    } aluOpT;

    localparam opcodeT opcodeOp    = 7'b0110011;
    localparam opcodeT opcodeOpImm = 7'b0010011;
    localparam opcodeT opcodeLui   = 7'b0110111;

    // funct3 field, bits 14:12
    localparam funct3T funct3AddSub = 3'd0;
    localparam funct3T funct3Sll    = 3'd1;
    localparam funct3T funct3Slt    = 3'd2;
    localparam funct3T funct3Sltu   = 3'd3;
    localparam funct3T funct3Xor    = 3'd4;
    localparam funct3T funct3SrlSra = 3'd5;
    localparam funct3T funct3Or     = 3'd6;
    localparam funct3T funct3And    = 3'd7;

    localparam funct7T funct7Base = 7'd0;
    localparam funct7T funct7Alt  = 7'd32;   // SUB / SRA

    // decode -> execute
    typedef struct packed {
        logic    valid;
        logic    writeEnable;
        regAddrT rd;
        aluOpT   opSel;
        xlenT    operandA;
        xlenT    operandB;
    } decodedT;

    // execute -> register file and bypass
    typedef struct packed {
        logic    valid;
        logic    writeEnable;
        regAddrT rd;
        xlenT    result;
    } retireT;

endpackage : rvAluPkg

`default_nettype wire

// File: tb.f
source/rvAluPkg.sv
source/aluOpDecode.sv
source/instrDecode.sv
source/aluExecute.sv
source/regFile.sv
source/aluPipeTop.sv
verif/aluPipeTb.sv

// File: verif/aluPipeTb.sv
// Directed tests for the two-stage ALU pipeline against an architectural register model.
// Retires are checked two cycles after issue, register contents through the debug port.
`timescale 1ns/1ps
`default_nettype none

module aluPipeTb import rvAluPkg::*; ();

    logic    clk;
    logic    reset;
    logic    instValid;
    xlenT    instWord;
    regAddrT debugAddr;
    xlenT    debugData;
    retireT  retired;

    xlenT        model [32];   // architectural state, x0 never written
    int          dueQ [$];     // cycle at which each expected retire shows up
    retireT      expQ [$];
    int          cycle;
    int          checkCount;
    int          errorCount;
    int          timeoutCount;
    logic [31:0] rngState;

    aluPipeTop i_dut (
        .clk       (clk),
        .reset     (reset),
        .instValid (instValid),
        .instWord  (instWord),
        .debugAddr (debugAddr),
        .debugData (debugData),
        .retired   (retired)
    );

    always #20 clk = ~clk;

    function automatic xlenT xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic xlenT encodeR(funct7T f7, regAddrT rs2, regAddrT rs1, funct3T f3,
                                     regAddrT rd);
        return {f7, rs2, rs1, f3, rd, opcodeOp};
    endfunction

    function automatic xlenT encodeI(logic [11:0] imm, regAddrT rs1, funct3T f3, regAddrT rd);
        return {imm, rs1, f3, rd, opcodeOpImm};
    endfunction

    function automatic xlenT encodeU(logic [19:0] upper, regAddrT rd);
        return {upper, rd, opcodeLui};
    endfunction

    // sel 0..7 is funct3 with funct7 zero, 8 is SUB, 9 is SRA
    function automatic xlenT encodeOp(int sel, regAddrT rs2, regAddrT rs1, regAddrT rd);
        if (sel == 8) begin
            return encodeR(funct7Alt, rs2, rs1, 3'd0, rd);
        end
        if (sel == 9) begin
            return encodeR(funct7Alt, rs2, rs1, 3'd5, rd);
        end
        return encodeR(7'd0, rs2, rs1, funct3T'(sel), rd);
    endfunction

    function automatic xlenT shiftRightArith(xlenT a, logic [4:0] sh);
        xlenT fill;
        fill = a[31] ? ~(32'hffff_ffff >> sh) : '0;
        return (a >> sh) | fill;
    endfunction

    // alt turns ADD into SUB and SRL into SRA
    function automatic xlenT aluModel(funct3T f3, logic alt, xlenT a, xlenT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return xlenT'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
            3'd3:    return xlenT'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? shiftRightArith(a, b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic retireT expectFor(xlenT w);
        retireT want;
        xlenT   a;
        xlenT   immI;
        a = model[w[19:15]];
        immI = {{20{w[31]}}, w[31:20]};
        want.valid = 1'b1;
        want.writeEnable = 1'b1;
        want.rd = w[11:7];
        want.result = '0;
        case (w[6:0])
            opcodeOp:    want.result = aluModel(w[14:12], w[30], a, model[w[24:20]]);
            opcodeOpImm: want.result = aluModel(w[14:12], w[14:12] == 3'd5 && w[30], a, immI);
            opcodeLui:   want.result = {w[31:12], 12'h000};
            default:     want.writeEnable = 1'b0;   // unknown opcode writes nothing
        endcase
        return want;
    endfunction

    task automatic compareRetire(retireT got, retireT want);
        checkCount++;
        if (got.valid !== want.valid || got.writeEnable !== want.writeEnable ||
            got.rd !== want.rd) begin
            errorCount++;
            $display("error at %0t: retired valid/writeEnable/rd got %b/%b/%0d expected %b/%b/%0d",
                     $time, got.valid, got.writeEnable, got.rd,
                     want.valid, want.writeEnable, want.rd);
        end
        if (want.writeEnable && got.result !== want.result) begin
            errorCount++;
            $display("error at %0t: retired.result got %h expected %h",
                     $time, got.result, want.result);
        end
    endtask

    task automatic compareWord(string name, xlenT got, xlenT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic checkRetireSlot();
        if (dueQ.size() > 0 && dueQ[0] == cycle) begin
            compareRetire(retired, expQ[0]);
            void'(dueQ.pop_front());
            void'(expQ.pop_front());
        end else if (retired.valid !== 1'b0) begin
            errorCount++;
            $display("error at %0t: retired.valid got %b expected 0", $time, retired.valid);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        cycle++;
        @(negedge clk);
        checkRetireSlot();
    endtask

    task automatic issueInst(xlenT w);
        retireT want;
        want = expectFor(w);
        if (want.writeEnable && want.rd != '0) begin
            model[want.rd] = want.result;
        end
        instValid = 1'b1;
        instWord  = w;
        dueQ.push_back(cycle + 2);   // accepted at the next edge, retired one edge later
        expQ.push_back(want);
        tick();
        instValid = 1'b0;
        instWord  = '0;
    endtask

    task automatic drainPipe();
        int waited;
        waited = 0;
        while (dueQ.size() > 0 && waited < 16) begin
            tick();
            waited++;
        end
        if (dueQ.size() > 0) begin
            timeoutCount++;
            $display("timeout: %0d expected retires never arrived", dueQ.size());
            dueQ.delete();
            expQ.delete();
        end
        tick();   // last write lands in the register file
    endtask

    task automatic readDebug(regAddrT addr, xlenT want);
        debugAddr = addr;
        tick();
        compareWord($sformatf("debugData[x%0d]", addr), debugData, want);
    endtask

    task automatic checkAllRegs();
        for (int a = 0; a < 32; a++) begin
            readDebug(regAddrT'(a), model[a]);
        end
        debugAddr = '0;
    endtask

    task automatic loadConst(regAddrT rd, xlenT value);
        xlenT rounded;
        rounded = value + 32'h800;   // ADDI sign-extends the low part
        issueInst(encodeU(rounded[31:12], rd));
        issueInst(encodeI(value[11:0], rd, 3'd0, rd));
    endtask

    task automatic testReset();
        tick();
        tick();
        checkAllRegs();
    endtask

    task automatic testLuiAddi();
        xlenT consts [4];
        consts[0] = 32'hdead_beef;
        consts[1] = 32'h1234_5fff;
        consts[2] = 32'h8000_0800;
        consts[3] = xorshift();
        for (int i = 0; i < 4; i++) begin
            loadConst(regAddrT'(i + 1), consts[i]);
        end
        drainPipe();
        for (int i = 0; i < 4; i++) begin
            readDebug(regAddrT'(i + 1), consts[i]);
        end
        checkAllRegs();
    endtask

    task automatic testOpReg();
        xlenT srcVals [4];
        srcVals[0] = xorshift() | 32'h8000_0000;   // negative, for SRA and SLT
        srcVals[1] = 32'h0000_0025;                // shift of 37 wraps to 5
        srcVals[2] = xorshift() & 32'h7fff_ffff;
        srcVals[3] = xorshift();
        for (int i = 0; i < 4; i++) begin
            loadConst(regAddrT'(5 + i), srcVals[i]);
        end
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 10; k++) begin
                issueInst(encodeOp(k, regAddrT'(5 + (p + 1) % 4), regAddrT'(5 + p),
                                   regAddrT'(10 + k)));
            end
        end
        drainPipe();
        checkAllRegs();
    endtask

    task automatic testOpImm();
        funct3T immOps [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        xlenT   r;
        for (int p = 5; p <= 8; p++) begin
            for (int k = 0; k < 6; k++) begin
                r = xorshift();
                if (k % 2 == 0) begin
                    r[11] = 1'b1;   // negative immediate
                end
                issueInst(encodeI(r[11:0], regAddrT'(p), immOps[k], regAddrT'(20 + k)));
            end
            r = xorshift();
            issueInst(encodeI({7'd0, r[4:0]}, regAddrT'(p), 3'd1, 5'd26));
            issueInst(encodeI({7'd0, r[4:0]}, regAddrT'(p), 3'd5, 5'd27));
            issueInst(encodeI({7'd32, r[4:0]}, regAddrT'(p), 3'd5, 5'd28));
        end
        drainPipe();
        checkAllRegs();
    endtask

    task automatic testDependentChains();
        xlenT r;
        int   sel;
        r = xorshift();
        issueInst(encodeI(r[11:0], 5'd0, 3'd0, 5'd1));
        issueInst(encodeR(7'd0, 5'd1, 5'd1, 3'd0, 5'd2));    // distance 1
        issueInst(encodeR(7'd0, 5'd1, 5'd2, 3'd0, 5'd3));    // distance 2 and 1
        issueInst(encodeR(funct7Alt, 5'd2, 5'd3, 3'd0, 5'd4));
        for (int n = 0; n < 24; n++) begin
            r = xorshift();
            sel = int'(r[9:6]) % 10;
            if (r[10]) begin
                issueInst(encodeOp(sel, regAddrT'(1 + r[5:4]), regAddrT'(1 + r[3:2]),
                                   regAddrT'(1 + r[1:0])));
            end else if (r[12:11] == 2'd1) begin
                // immediate shift, bit 30 picks SRAI
                issueInst(encodeI({1'b0, r[30], 5'd0, r[24:20]}, regAddrT'(1 + r[3:2]),
                                  {r[13], 2'b01}, regAddrT'(1 + r[1:0])));
            end else begin
                issueInst(encodeI(r[31:20], regAddrT'(1 + r[3:2]), {r[13], r[12:11]} & 3'b110,
                                  regAddrT'(1 + r[1:0])));
            end
        end
        drainPipe();
        checkAllRegs();
    endtask

    task automatic testX0AndUnknown();
        xlenT r;
        r = xorshift();
        issueInst(encodeI(12'h005, 5'd1, 3'd0, 5'd0));        // addi x0, x1, 5
        issueInst(encodeR(7'd0, 5'd0, 5'd0, 3'd0, 5'd9));     // reads x0 right after
        issueInst(encodeR(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));
        issueInst({12'h004, 5'd2, 3'd2, 5'd1, 7'b0000011});   // load
        issueInst({r[31:12], 5'd3, 7'b0010111});              // auipc
        issueInst({r[31:12], 5'd4, 7'b1101111});              // jal
        issueInst(encodeR(7'd0, 5'd3, 5'd1, 3'd0, 5'd9));     // must see the old x1
        drainPipe();
        readDebug(5'd0, '0);
        checkAllRegs();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        debugAddr = '0;
        rngState = 32'd4;
        cycle = 0;
        checkCount = 0;
        errorCount = 0;
        timeoutCount = 0;
        for (int a = 0; a < 32; a++) begin
            model[a] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testReset();
        testLuiAddi();
        testOpReg();
        testOpImm();
        testDependentChains();
        testX0AndUnknown();

        $display("checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : aluPipeTb

`default_nettype wire
